//--- icache_ctrl_unit.f
+incdir+verilog
verilog/icache_ctrl_pkg.sv
verilog/icache_ack_tracker.sv
verilog/icache_ctrl_regs.sv
verilog/icache_ctrl_fsm.sv
verilog/icache_ctrl_unit.sv
testbench/tb_icache_ctrl_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f icache_ctrl_unit.f \
    --top-module tb_icache_ctrl_unit -o sim_tb \
    && out="$(./obj_dir/sim_tb)" \
    || { echo "build or simulation error"; exit 1; }

echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

//--- testbench/icache_ctrl_patterns.txt
# columns (hex): op reg wdata expect id; op 0 read, 1 write, 2 write with a queued read
# expect is read data for reads, the raised request mask for writes; queued reads expect 0
0 00 00000000 00000000 01
1 00 0000000f 0000000f 02
0 00 00000000 0000000f 03
1 00 00000005 00000005 04
0 00 00000000 00000005 05
1 3f 00000001 00000000 06
0 3f 00000000 00000001 07
1 03 00000020 00000004 08
0 03 00000000 00000020 09
1 03 12345670 00000008 0a
0 03 00000000 12345670 0b
0 05 00000000 badacce5 0c
0 20 00000000 badacce5 0d
1 05 0000dead 00000000 0e
1 01 0000000b 0000000b 0f
0 01 00000000 00000000 10
1 02 00000006 00000006 11
0 02 00000000 00000000 12
1 01 00000000 00000000 13
1 02 00000000 00000000 14
2 01 0000000f 0000000f 15
2 02 00000009 00000009 17
1 3f 00000000 00000000 19
0 3f 00000000 00000000 1a
1 00 00000000 00000000 1b
0 00 00000000 00000000 1c

//--- testbench/tb_icache_ctrl_unit.sv
// Pattern file path is relative to the project root; bank and core models answer within 1 to 8 cycles
`include "icache_ctrl_defines.svh"
`default_nettype none

module tb_icache_ctrl_unit
    import icache_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic           clk_i;
    logic           rst_ni;
    periph_req_t    bus_req;
    logic           gnt;
    periph_rsp_t    bus_rsp;
    bank_ctrl_req_t bank_req;
    bank_ctrl_ack_t bank_ack;
    core_mask_t     l0_flush_req;
    core_mask_t     l0_flush_ack;

    logic [31:0] lfsr = 32'hb28e_0679;
    int          errors = 0;
    int          n_lines = 0;
    int          pst[12];              // Pulse models: 0 idle, 1 counting, 2 pulsed, 3 wait drop
    int          pcnt[12];
    logic [11:0] pack;                 // {sel flush, L0, bank flush} acks
    logic [3:0]  elvl;
    logic [3:0]  epend;
    int          ecnt[4];

    icache_ctrl_unit uut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .bus_req      (bus_req),
        .gnt          (gnt),
        .bus_rsp      (bus_rsp),
        .bank_req     (bank_req),
        .bank_ack     (bank_ack),
        .l0_flush_req (l0_flush_req),
        .l0_flush_ack (l0_flush_ack)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic note_mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    // Bank and core responders, stepped just after each rising edge
    initial
    begin
        int          r;
        logic [11:0] preq;
        bank_ack     = '0;
        l0_flush_ack = '0;
        pack         = '0;
        elvl         = '0;
        epend        = '1;     // Disable level is up from reset
        for (int i = 0; i < 12; i++)
        begin
            pst[i]  = 0;
            pcnt[i] = 0;
        end
        for (int b = 0; b < 4; b++)
            ecnt[b] = 0;
        forever
        begin
            @(posedge clk_i);
            #2;
            for (int b = 0; b < 4; b++)
            begin
                if (bank_req.req_enable[b] != elvl[b])
                begin
                    elvl[b]  = bank_req.req_enable[b];
                    epend[b] = 1'b1;
                    take_bits(3, r);
                    ecnt[b]  = r;
                    bank_ack.ack_enable[b]  = 1'b0;
                    bank_ack.ack_disable[b] = 1'b0;
                end
                else if (epend[b])
                begin
                    if (ecnt[b] == 0)
                    begin
                        epend[b] = 1'b0;
                        bank_ack.ack_enable[b]  = elvl[b];    // Held while level is stable
                        bank_ack.ack_disable[b] = ~elvl[b];
                    end
                    else
                        ecnt[b]--;
                end
            end
            preq = {bank_req.sel_flush_req, l0_flush_req, bank_req.flush_req};
            for (int c = 0; c < 12; c++)
            begin
                case (pst[c])
                    0: if (preq[c])
                    begin
                        take_bits(3, r);
                        pcnt[c] = r;
                        pst[c]  = 1;
                    end
                    1: if (pcnt[c] == 0)
                    begin
                        pack[c] = 1'b1;
                        pst[c]  = 2;
                    end
                    else
                        pcnt[c]--;
                    2:
                    begin
                        pack[c] = 1'b0;
                        pst[c]  = 3;
                    end
                    default: if (!preq[c])
                        pst[c] = 0;
                endcase
            end
            bank_ack.flush_ack     = pack[3:0];
            l0_flush_ack           = pack[7:4];
            bank_ack.sel_flush_ack = pack[11:8];
        end
    end

    task automatic issue(input logic rd, input logic [5:0] rg, input logic [31:0] wd,
                         input logic [4:0] id);
        bus_req.req   = 1'b1;
        bus_req.addr  = {24'd0, rg, 2'b00};
        bus_req.wen   = rd;
        bus_req.wdata = wd;
        bus_req.id    = id;
    endtask

    // Returns just after the accepting edge
    task automatic wait_accept(input logic at_negedge);
        int n;
        n = 0;
        if (!at_negedge)
            @(negedge clk_i);
        while (!gnt && n < 200)
        begin
            n++;
            @(negedge clk_i);
        end
        assert (gnt) else note_failure("request was never granted");
        @(posedge clk_i);
        #2;
        bus_req.req = 1'b0;
    endtask

    task automatic check_read(input logic [31:0] ex, input logic [4:0] id);
        @(negedge clk_i);
        assert (bus_rsp.r_valid) else note_failure("no read response one cycle after grant");
        assert (bus_rsp.r_id == id) else note_mismatch("r_id", 32'(bus_rsp.r_id), 32'(id));
        assert (bus_rsp.r_rdata == ex) else note_mismatch("r_rdata", bus_rsp.r_rdata, ex);
    endtask

    task automatic run_write(input logic [5:0] rg, input logic [31:0] wd, input logic [31:0] ex,
                             input logic [4:0] id, input logic queue_read);
        int         waited;
        bank_mask_t fl_acked;
        core_mask_t l0_acked;
        waited   = 0;
        fl_acked = '0;
        l0_acked = '0;
        issue(1'b0, rg, wd, id);
        wait_accept(1'b0);
        if (queue_read)
            issue(1'b1, rg, 32'd0, id + 5'd1);   // Held until the grant returns
        @(negedge clk_i);
        case (rg)
            `ICC_REG_ENABLE:
            begin
                assert (bank_req.req_enable == ex[3:0])
                    else note_mismatch("req_enable", 32'(bank_req.req_enable), ex);
                assert (bank_req.req_disable == ~ex[3:0])
                    else note_mismatch("req_disable", 32'(bank_req.req_disable), ~ex);
            end
            `ICC_REG_FLUSH: assert (bank_req.flush_req == ex[3:0])
                else note_mismatch("flush_req", 32'(bank_req.flush_req), ex);
            `ICC_REG_FLUSH_L0: assert (l0_flush_req == ex[3:0])
                else note_mismatch("l0_flush_req", 32'(l0_flush_req), ex);
            default: ;
        endcase
        while (!bus_rsp.r_valid && waited < 200)
        begin
            assert (!gnt) else note_failure("grant high while an operation waits");
            assert ((bank_req.flush_req & fl_acked) == '0)
                else note_mismatch("flush_req after ack", 32'(bank_req.flush_req), 32'd0);
            assert ((l0_flush_req & l0_acked) == '0)
                else note_mismatch("l0_flush_req after ack", 32'(l0_flush_req), 32'd0);
            if (rg == `ICC_REG_SEL_FLUSH)
            begin
                assert (bank_req.sel_flush_req == ex[3:0])
                    else note_mismatch("sel_flush_req", 32'(bank_req.sel_flush_req), ex);
                assert (bank_req.sel_flush_addr == wd)
                    else note_mismatch("sel_flush_addr", bank_req.sel_flush_addr, wd);
            end
            fl_acked = fl_acked | bank_ack.flush_ack;
            l0_acked = l0_acked | l0_flush_ack;
            waited++;
            @(negedge clk_i);
        end
        assert (bus_rsp.r_valid) else note_failure("write response never arrived");
        assert (bus_rsp.r_id == id) else note_mismatch("r_id", 32'(bus_rsp.r_id), 32'(id));
        assert (bus_rsp.r_rdata == '0) else note_mismatch("write r_rdata", bus_rsp.r_rdata, 32'd0);
        if (rg > `ICC_REG_SEL_FLUSH)
            assert (waited == 0) else note_failure("simple write not answered in one cycle");
        if (rg == `ICC_REG_PRIVATE)
            assert (bank_req.is_private == wd[0])
                else note_mismatch("is_private", 32'(bank_req.is_private), 32'(wd[0]));
        if (rg == `ICC_REG_ENABLE)
            assert (bank_ack.ack_enable == ex[3:0] && bank_ack.ack_disable == ~ex[3:0])
                else note_failure("enable write answered before all banks acknowledged");
        if (rg == `ICC_REG_FLUSH)
            assert (fl_acked == ex[3:0]) else note_mismatch("acked banks", 32'(fl_acked), ex);
        if (rg == `ICC_REG_FLUSH_L0)
            assert (l0_acked == ex[3:0]) else note_mismatch("acked cores", 32'(l0_acked), ex);
        if (queue_read)
        begin
            wait_accept(1'b1);
            check_read(32'd0, id + 5'd1);   // Flush registers have cleared
        end
    endtask

    initial
    begin
        @(posedge rst_ni);
        repeat (n_lines * 200 + 20) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", n_lines * 200 + 20);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        int          fd;
        int          code;
        int          tests;
        int          err_before;
        string       line;
        logic [31:0] op;
        logic [31:0] rg;
        logic [31:0] wd;
        logic [31:0] ex;
        logic [31:0] id;
        tests   = 0;
        bus_req = '0;
        rst_ni  = 1'b0;
        fd = $fopen("testbench/icache_ctrl_patterns.txt", "r");
        while (fd != 0 && !$feof(fd))
        begin
            code = $fgets(line, fd);
            if (code > 0 && $sscanf(line, "%h %h %h %h %h", op, rg, wd, ex, id) == 5)
                n_lines++;
        end
        if (fd != 0)
            $fclose(fd);
        assert (n_lines > 0) else note_failure("pattern file missing or empty");
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(negedge clk_i);
        assert (gnt && !bus_rsp.r_valid && bank_req.req_disable == '1 && !bank_req.is_private
                && bank_req.req_enable == '0 && bank_req.flush_req == '0 && l0_flush_req == '0)
            else note_failure("outputs wrong after reset");
        @(posedge clk_i);
        #2;
        fd = $fopen("testbench/icache_ctrl_patterns.txt", "r");
        while (fd != 0 && !$feof(fd))
        begin
            code = $fgets(line, fd);
            if (code > 0 && $sscanf(line, "%h %h %h %h %h", op, rg, wd, ex, id) == 5)
            begin
                err_before = errors;
                tests++;
                if (op == 0)
                begin
                    issue(1'b1, rg[5:0], 32'd0, id[4:0]);
                    wait_accept(1'b0);
                    check_read(ex, id[4:0]);
                end
                else
                    run_write(rg[5:0], wd, ex, id[4:0], op == 2);
                @(posedge clk_i);
                #2;
                $display("test %0d op %0d reg %02h: %s", tests, op, rg[5:0],
                         (errors == err_before) ? "ok" : "error");
            end
        end
        if (fd != 0)
            $fclose(fd);
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/icache_ack_tracker.sv
// Bits stay recorded until clear; the owner must not listen and clear in the same cycle
`default_nettype none

module icache_ack_tracker #(
    parameter type mask_t = logic [3:0]
)
(
    input  wire logic  clk_i,
    input  wire logic  rst_ni,

    input  wire logic  listen,
    input  wire logic  clear,
    input  wire mask_t ack,
    input  wire mask_t wanted,

    output mask_t      seen,
    output logic       all_done
);

    mask_t seen_q;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            seen_q <= '0;
        else if (clear)
            seen_q <= '0;
        else if (listen)
            seen_q <= seen_q | ack;   // Sticky, acks may be single pulses
    end

    assign seen = seen_q;

    // An empty wanted mask counts as done
    assign all_done = ((seen_q & wanted) == wanted);

    a_listen_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(listen && clear));

endmodule

`default_nettype wire

//--- verilog/icache_ctrl_defines.svh
// Sizes are fixed at compile time; the bank count must be a power of two for selective flush
`ifndef ICACHE_CTRL_DEFINES_SVH
`define ICACHE_CTRL_DEFINES_SVH

// Cluster sizing
`define ICC_NB_BANKS        4
`define ICC_NB_CORES        4
`define ICC_ID_WIDTH        5       // Peripheral bus transaction id

// Lowest address bit of the bank index in a selective-flush address
`define ICC_SEL_OFFSET      4

// Register word indices, taken from bus address bits 7 to 2
`define ICC_REG_ENABLE      6'd0    // Per-bank enable, reads back
`define ICC_REG_FLUSH       6'd1    // Full bank flush, clears itself
`define ICC_REG_FLUSH_L0    6'd2    // Per-core L0 flush, clears itself
`define ICC_REG_SEL_FLUSH   6'd3    // Address to flush
`define ICC_REG_PRIVATE     6'd63   // Private/shared mode bit

// Read value for any index not listed above
`define ICC_BAD_ACCESS      32'hbada_cce5

`endif

//--- verilog/icache_ctrl_fsm.sv
// One operation at a time; the bus is held off by gnt until the running operation responds
`include "icache_ctrl_defines.svh"
`default_nettype none

module icache_ctrl_fsm
    import icache_ctrl_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_ni,

    input  wire periph_req_t bus_req,
    output logic             gnt,
    output logic             is_read,
    output logic             is_write,
    output logic             respond,

    input  wire logic [31:0] sel_flush_addr,
    input  wire bank_mask_t  sel_ack,
    output bank_mask_t       sel_req,

    output logic             listen_enable,
    output logic             listen_flush,
    output logic             listen_l0,
    output logic             clear_flush,
    output logic             clear_l0,
    output logic             clear_enable,

    input  wire logic        enable_done,
    input  wire logic        flush_done,
    input  wire logic        l0_done
);

    localparam int sel_bits = $clog2(`ICC_NB_BANKS);

    icc_op_t             state_q;
    icc_op_t             state_d;
    logic [sel_bits-1:0] sel_idx;

    // Bank that owns the address
    assign sel_idx = sel_flush_addr[`ICC_SEL_OFFSET +: sel_bits];

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            state_q <= op_idle;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d       = state_q;
        gnt           = 1'b0;
        is_read       = 1'b0;
        is_write      = 1'b0;
        respond       = 1'b0;
        sel_req       = '0;
        listen_enable = 1'b0;
        listen_flush  = 1'b0;
        listen_l0     = 1'b0;
        clear_flush   = 1'b0;
        clear_l0      = 1'b0;
        clear_enable  = 1'b0;

        case (state_q)
            op_idle:
            begin
                gnt = 1'b1;
                if (bus_req.req)
                begin
                    if (bus_req.wen)
                    begin
                        is_read = 1'b1;
                        respond = 1'b1;
                    end
                    else
                    begin
                        is_write = 1'b1;
                        case (bus_req.addr[7:2])
                            `ICC_REG_ENABLE:    state_d = op_enable_wait;
                            `ICC_REG_FLUSH:     state_d = op_flush_wait;
                            `ICC_REG_FLUSH_L0:  state_d = op_l0_wait;
                            `ICC_REG_SEL_FLUSH: state_d = op_sel_flush_wait;
                            default:            respond = 1'b1;   // Private bit or unmapped
                        endcase
                    end
                end
            end

            op_enable_wait:
            begin
                if (enable_done)
                begin
                    respond      = 1'b1;
                    clear_enable = 1'b1;
                    state_d      = op_idle;
                end
                else
                    listen_enable = 1'b1;
            end

            op_flush_wait:
            begin
                if (flush_done)
                begin
                    respond     = 1'b1;
                    clear_flush = 1'b1;
                    state_d     = op_idle;
                end
                else
                    listen_flush = 1'b1;
            end

            op_l0_wait:
            begin
                if (l0_done)
                begin
                    respond  = 1'b1;
                    clear_l0 = 1'b1;
                    state_d  = op_l0_done;
                end
                else
                    listen_l0 = 1'b1;
            end

            // L0 levels settle low before the next grant
            op_l0_done:
                state_d = op_idle;

            op_sel_flush_wait:
            begin
                sel_req[sel_idx] = 1'b1;
                if (sel_ack[sel_idx])
                begin
                    respond = 1'b1;
                    state_d = op_idle;
                end
            end

            default:
                state_d = op_idle;
        endcase
    end

    // The selected bank stays fixed while its request is up
    a_sel_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == op_sel_flush_wait && !respond) |=> $stable(sel_idx));

endmodule

`default_nettype wire

//--- verilog/icache_ctrl_pkg.sv
// Field widths come from the defines header; the id width must match the bus master
`include "icache_ctrl_defines.svh"
`default_nettype none

package icache_ctrl_pkg;

    typedef logic [`ICC_NB_BANKS-1:0] bank_mask_t;   // One bit per cache bank
    typedef logic [`ICC_NB_CORES-1:0] core_mask_t;   // One bit per L0 fetch buffer

    // Peripheral bus request, wen high means read
    typedef struct packed {
        logic                     req;
        logic [31:0]              addr;
        logic                     wen;
        logic [31:0]              wdata;
        logic [`ICC_ID_WIDTH-1:0] id;
    } periph_req_t;

    // Peripheral bus response
    typedef struct packed {
        logic                     r_valid;
        logic [`ICC_ID_WIDTH-1:0] r_id;
        logic [31:0]              r_rdata;
    } periph_rsp_t;

    // Control levels towards all cache banks
    typedef struct packed {
        bank_mask_t  req_enable;
        bank_mask_t  req_disable;
        bank_mask_t  flush_req;
        bank_mask_t  sel_flush_req;
        logic [31:0] sel_flush_addr;   // Shared by all banks
        logic        is_private;
    } bank_ctrl_req_t;

    // Acknowledges back from the banks, pulse or hold
    typedef struct packed {
        bank_mask_t ack_enable;
        bank_mask_t ack_disable;
        bank_mask_t flush_ack;
        bank_mask_t sel_flush_ack;
    } bank_ctrl_ack_t;

    // Operation sequencer states
    typedef enum logic [2:0] {
        op_idle,
        op_enable_wait,
        op_flush_wait,
        op_l0_wait,
        op_l0_done,        // Guard cycle after an L0 flush
        op_sel_flush_wait
    } icc_op_t;

endpackage

`default_nettype wire

//--- verilog/icache_ctrl_regs.sv
// Only address bits 7 to 2 select a register; writes of unmapped indices are dropped
`include "icache_ctrl_defines.svh"
`default_nettype none

module icache_ctrl_regs
    import icache_ctrl_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_ni,

    input  wire periph_req_t bus_req,
    input  wire logic        is_read,
    input  wire logic        is_write,
    input  wire logic        clear_flush,
    input  wire logic        clear_l0,

    output periph_rsp_t      bus_rsp,
    input  wire logic        respond,

    output bank_mask_t       enable_mask,
    output bank_mask_t       flush_mask,
    output core_mask_t       l0_mask,
    output logic [31:0]      sel_flush_addr,
    output logic             is_private
);

    logic [5:0]               reg_idx;
    bank_mask_t               enable_q;
    bank_mask_t               flush_q;
    core_mask_t               l0_q;
    logic [31:0]              sel_addr_q;
    logic                     private_q;
    logic [31:0]              rdata;

    logic                     r_valid_q;
    logic [`ICC_ID_WIDTH-1:0] r_id_q;
    logic [31:0]              r_rdata_q;

    assign reg_idx = bus_req.addr[7:2];

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            enable_q   <= '0;      // All banks disabled
            flush_q    <= '0;
            l0_q       <= '0;
            sel_addr_q <= '0;
            private_q  <= 1'b0;
        end
        else if (is_write)
        begin
            case (reg_idx)
                `ICC_REG_ENABLE:    enable_q   <= bus_req.wdata[`ICC_NB_BANKS-1:0];
                `ICC_REG_FLUSH:     flush_q    <= bus_req.wdata[`ICC_NB_BANKS-1:0];
                `ICC_REG_FLUSH_L0:  l0_q       <= bus_req.wdata[`ICC_NB_CORES-1:0];
                `ICC_REG_SEL_FLUSH: sel_addr_q <= bus_req.wdata;
                `ICC_REG_PRIVATE:   private_q  <= bus_req.wdata[0];
                default:            ;
            endcase
        end
        else
        begin
            // Flush masks drop once every target has answered
            if (clear_flush)
                flush_q <= '0;
            if (clear_l0)
                l0_q <= '0;
        end
    end

    // Read mux
    always_comb
    begin
        case (reg_idx)
            `ICC_REG_ENABLE:    rdata = 32'(enable_q);
            `ICC_REG_FLUSH:     rdata = 32'(flush_q);
            `ICC_REG_FLUSH_L0:  rdata = 32'(l0_q);
            `ICC_REG_SEL_FLUSH: rdata = sel_addr_q;
            `ICC_REG_PRIVATE:   rdata = {31'd0, private_q};
            default:            rdata = `ICC_BAD_ACCESS;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            r_valid_q <= 1'b0;
        else
            r_valid_q <= is_read | respond;
    end

    // Response payload, write responses carry zero
    always_ff @(posedge clk_i)
    begin
        if (is_read || is_write)
            r_id_q <= bus_req.id;
        if (is_read)
            r_rdata_q <= rdata;
        else if (respond)
            r_rdata_q <= '0;
    end

    assign bus_rsp.r_valid = r_valid_q;
    assign bus_rsp.r_id    = r_id_q;
    assign bus_rsp.r_rdata = r_rdata_q;

    assign enable_mask    = enable_q;
    assign flush_mask     = flush_q;
    assign l0_mask        = l0_q;
    assign sel_flush_addr = sel_addr_q;
    assign is_private     = private_q;

    // Clears come only from wait states, where the bus is not granted
    a_clear_vs_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (clear_flush || clear_l0) |-> !is_write);

endmodule

`default_nettype wire

//--- verilog/icache_ctrl_unit.sv
// Request levels are not retimed; banks and cores see them straight from registers and FSM
`default_nettype none

module icache_ctrl_unit
    import icache_ctrl_pkg::*;
(
    input  wire logic           clk_i,
    input  wire logic           rst_ni,

    input  wire periph_req_t    bus_req,
    output logic                gnt,
    output periph_rsp_t         bus_rsp,

    output bank_ctrl_req_t      bank_req,
    input  wire bank_ctrl_ack_t bank_ack,

    output core_mask_t          l0_flush_req,
    input  wire core_mask_t     l0_flush_ack
);

    bank_mask_t  enable_mask;
    bank_mask_t  flush_mask;
    core_mask_t  l0_mask;
    logic [31:0] sel_flush_addr;
    logic        is_private;

    logic        is_read;
    logic        is_write;
    logic        respond;
    bank_mask_t  sel_req;
    logic        listen_enable;
    logic        listen_flush;
    logic        listen_l0;
    logic        clear_enable;
    logic        clear_flush;
    logic        clear_l0;
    logic        enable_done;
    logic        flush_done;
    logic        l0_done;

    bank_mask_t  enable_ack;
    bank_mask_t  flush_seen;
    core_mask_t  l0_seen;

    // Each bank answers on the ack that matches its new level
    assign enable_ack = (enable_mask & bank_ack.ack_enable) | (~enable_mask & bank_ack.ack_disable);

    icache_ctrl_regs u_regs (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .bus_req        (bus_req),
        .is_read        (is_read),
        .is_write       (is_write),
        .clear_flush    (clear_flush),
        .clear_l0       (clear_l0),
        .bus_rsp        (bus_rsp),
        .respond        (respond),
        .enable_mask    (enable_mask),
        .flush_mask     (flush_mask),
        .l0_mask        (l0_mask),
        .sel_flush_addr (sel_flush_addr),
        .is_private     (is_private)
    );

    icache_ctrl_fsm u_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .bus_req        (bus_req),
        .gnt            (gnt),
        .is_read        (is_read),
        .is_write       (is_write),
        .respond        (respond),
        .sel_flush_addr (sel_flush_addr),
        .sel_ack        (bank_ack.sel_flush_ack),
        .sel_req        (sel_req),
        .listen_enable  (listen_enable),
        .listen_flush   (listen_flush),
        .listen_l0      (listen_l0),
        .clear_flush    (clear_flush),
        .clear_l0       (clear_l0),
        .clear_enable   (clear_enable),
        .enable_done    (enable_done),
        .flush_done     (flush_done),
        .l0_done        (l0_done)
    );

    // Every bank must confirm its enable or disable level
    icache_ack_tracker #(.mask_t(bank_mask_t)) u_enable_tracker (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .listen   (listen_enable),
        .clear    (clear_enable),
        .ack      (enable_ack),
        .wanted   ('1),
        .seen     (),
        .all_done (enable_done)
    );

    icache_ack_tracker #(.mask_t(bank_mask_t)) u_flush_tracker (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .listen   (listen_flush),
        .clear    (clear_flush),
        .ack      (bank_ack.flush_ack),
        .wanted   (flush_mask),
        .seen     (flush_seen),
        .all_done (flush_done)
    );

    icache_ack_tracker #(.mask_t(core_mask_t)) u_l0_tracker (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .listen   (listen_l0),
        .clear    (clear_l0),
        .ack      (l0_flush_ack),
        .wanted   (l0_mask),
        .seen     (l0_seen),
        .all_done (l0_done)
    );

    assign bank_req.req_enable     = enable_mask;
    assign bank_req.req_disable    = ~enable_mask;
    assign bank_req.flush_req      = flush_mask & ~flush_seen;   // Drops per bank once acked
    assign bank_req.sel_flush_req  = sel_req;
    assign bank_req.sel_flush_addr = sel_flush_addr;
    assign bank_req.is_private     = is_private;

    assign l0_flush_req = l0_mask & ~l0_seen;

endmodule

`default_nettype wire
